//--- vlog.f
+incdir+.
mm_pkg.sv
mm_addr_decode.sv
mm_dp_ram.sv
mm_periph.sv
mm_rsp_mux.sv
mm_ram_top.sv
mm_ram_props.sv
tb_mm_ram.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the RAM wrapper testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mm_ram -f vlog.f -o tb_mm_ram

./obj_dir/tb_mm_ram 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation finished without errors"

//--- tb_mm_ram.sv
/*
 * testbench of the memory-mapped RAM wrapper
 * random data traffic, fetches, error accesses, timer and status/exit checks
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module tb_mm_ram;
    import mm_pkg::*;

    localparam int AW         = `MM_RAM_ADDR_WIDTH;
    localparam int unsigned RAM_BYTES = 2 ** AW;
    localparam int NUM_FILL   = 256;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_FETCH  = 40;
    localparam int TIMER_N    = 20;
    // about 600 cycles of traffic plus a wide margin
    localparam int MAX_CYCLES = 5000;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          instr_req_i;
    logic [AW-1:0]                 instr_addr_i;
    logic                          instr_gnt_o;
    logic                          instr_rvalid_o;
    logic [`MM_INSTR_WIDTH-1:0]    instr_rdata_o;
    logic                          data_req_i;
    mm_data_req_t                  data_req_s_i;
    logic                          data_gnt_o;
    logic                          data_rvalid_o;
    logic [`MM_DATA_WIDTH-1:0]     data_rdata_o;
    logic                          irq_ack_i;
    logic [4:0]                    irq_id_i;
    logic                          irq_o;
    logic                          tests_passed_o;
    logic                          tests_failed_o;
    logic                          exit_valid_o;
    logic [`MM_DATA_WIDTH-1:0]     exit_value_o;

    int          errors = 0;
    int          checks = 0;
    int          cycles;
    logic [31:0] lfsr;

    // reference model state
    logic [7:0]   model_mem [0:RAM_BYTES-1];
    logic [31:0]  model_mask;
    logic [31:0]  model_cnt;
    logic         model_irq;
    logic         model_passed;
    logic         model_failed;
    logic         model_exit_valid;
    logic [31:0]  model_exit_value;
    logic         data_pending;
    logic         instr_pending;
    logic [31:0]  exp_data_q [$];
    logic         exp_read_q [$];
    logic [127:0] exp_instr_q [$];

    mm_ram_top UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_req_s_i   (data_req_s_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    bind mm_ram_top mm_ram_props u_props (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_gnt_i    (instr_gnt_o),
        .instr_rvalid_i (instr_rvalid_o),
        .data_req_i     (data_req_i),
        .data_gnt_i     (data_gnt_o),
        .data_rvalid_i  (data_rvalid_o),
        .irq_i          (irq_o),
        .tests_passed_i (tests_passed_o),
        .tests_failed_i (tests_failed_o),
        .timer_mask_i   (u_periph.timer_mask_q)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] expected_read_data(input logic [31:0] addr);
        logic [31:0]   w;
        logic [AW-1:0] base;
        w    = '0;
        base = {addr[AW-1:2], 2'b00};
        if (addr < RAM_BYTES) begin
            for (int k = 0; k < 4; k++) begin
                w[8*k +: 8] = model_mem[base + AW'(k)];
            end
        end else if (addr == `MM_TIMER_MASK_ADDR) begin
            w = model_mask;
        end else if (addr == `MM_TIMER_CNT_ADDR) begin
            w = model_cnt;
        end
        return w;
    endfunction

    // sixteen bytes that wrap at the top of the RAM
    function automatic logic [127:0] expected_fetch_data(input logic [AW-1:0] iaddr);
        logic [127:0] r;
        for (int i = 0; i < 16; i++) begin
            r[8*i +: 8] = model_mem[iaddr + AW'(i)];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk_i) begin : reference_check
        logic [31:0]   a;
        logic [31:0]   wd;
        logic [AW-1:0] base;
        logic          wr;
        logic          timer_wr;
        logic          fire;
        logic          clr;
        if (!rst_ni) begin
            model_mask       = '0;
            model_cnt        = '0;
            model_irq        = 1'b0;
            model_passed     = 1'b0;
            model_failed     = 1'b0;
            model_exit_valid = 1'b0;
            model_exit_value = '0;
            data_pending     = 1'b0;
            instr_pending    = 1'b0;
            exp_data_q.delete();
            exp_read_q.delete();
            exp_instr_q.delete();
        end else begin
            // responses to the previous cycle's requests
            check_value("data_rvalid_o", 128'(data_rvalid_o), 128'(data_pending));
            if (data_rvalid_o && exp_data_q.size() > 0) begin
                a = exp_data_q.pop_front();
                if (exp_read_q.pop_front()) begin
                    check_value("data_rdata_o", 128'(data_rdata_o), 128'(a));
                end
            end
            check_value("instr_rvalid_o", 128'(instr_rvalid_o), 128'(instr_pending));
            if (instr_rvalid_o && exp_instr_q.size() > 0) begin
                check_value("instr_rdata_o", instr_rdata_o, exp_instr_q.pop_front());
            end
            check_value("instr_gnt_o", 128'(instr_gnt_o), 128'(instr_req_i));
            check_value("data_gnt_o", 128'(data_gnt_o), 128'(data_req_i));
            check_value("irq_o", 128'(irq_o), 128'(model_irq));
            check_value("tests_passed_o", 128'(tests_passed_o), 128'(model_passed));
            check_value("tests_failed_o", 128'(tests_failed_o), 128'(model_failed));
            check_value("exit_valid_o", 128'(exit_valid_o), 128'(model_exit_valid));
            check_value("exit_value_o", 128'(exit_value_o), 128'(model_exit_value));

            // requests granted in this cycle
            instr_pending = instr_req_i;
            data_pending  = data_req_i;
            if (instr_pending) begin
                exp_instr_q.push_back(expected_fetch_data(instr_addr_i));
            end
            a  = data_req_s_i.addr;
            wd = data_req_s_i.wdata;
            if (data_pending) begin
                exp_data_q.push_back(expected_read_data(a));
                exp_read_q.push_back(!data_req_s_i.we);
            end

            // register state after the coming edge
            wr       = data_pending && data_req_s_i.we;
            timer_wr = wr && (a == `MM_TIMER_MASK_ADDR || a == `MM_TIMER_CNT_ADDR);
            fire     = !timer_wr && model_cnt == 32'd1 && model_mask[`MM_TIMER_IRQ_ID];
            clr      = irq_ack_i && irq_id_i == `MM_TIMER_IRQ_ID;
            model_passed     = wr && a == `MM_TEST_STATUS_ADDR && wd == `MM_TEST_PASS_CODE;
            model_failed     = wr && a == `MM_TEST_STATUS_ADDR && wd == `MM_TEST_FAIL_CODE;
            model_exit_valid = wr && a == `MM_EXIT_ADDR;
            if (model_exit_valid) begin
                model_exit_value = wd;
            end
            if (clr) begin
                model_irq = 1'b0;
            end else if (fire) begin
                model_irq = 1'b1;
            end
            if (wr && a == `MM_TIMER_CNT_ADDR) begin
                model_cnt = wd;
            end else if (!timer_wr && model_cnt != '0) begin
                model_cnt = model_cnt - 32'd1;
            end
            if (wr && a == `MM_TIMER_MASK_ADDR) begin
                model_mask = wd;
            end
            base = {a[AW-1:2], 2'b00};
            if (wr && a < RAM_BYTES) begin
                for (int k = 0; k < 4; k++) begin
                    if (data_req_s_i.be[k]) begin
                        model_mem[base + AW'(k)] = wd[8*k +: 8];
                    end
                end
            end
        end
    end

    task automatic drive_cycle(input logic ireq, input logic [AW-1:0] iaddr,
                               input logic dreq, input logic we, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] wdata);
        @(posedge clk_i);
        #1;
        instr_req_i        = ireq;
        instr_addr_i       = iaddr;
        data_req_i         = dreq;
        data_req_s_i.we    = we;
        data_req_s_i.addr  = addr;
        data_req_s_i.be    = be;
        data_req_s_i.wdata = wdata;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata);
        drive_cycle(1'b0, '0, 1'b1, 1'b1, addr, 4'hF, wdata);
    endtask

    task automatic read_word(input logic [31:0] addr);
        drive_cycle(1'b0, '0, 1'b1, 1'b0, addr, 4'h0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, 4'h0, '0);
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (irq_o !== 1'b1 && n < limit) begin
            idle(1);
            n++;
        end
        if (irq_o !== 1'b1) begin
            errors++;
            $display("timer interrupt did not rise within %0d cycles", limit);
        end
    endtask

    task automatic wait_responses(input int limit);
        int n;
        n = 0;
        while ((exp_data_q.size() != 0 || exp_instr_q.size() != 0) && n < limit) begin
            idle(1);
            n++;
        end
        if (exp_data_q.size() != 0 || exp_instr_q.size() != 0) begin
            errors++;
            $display("responses still missing after %0d idle cycles", limit);
        end
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        errors++;
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r_we;
        logic [31:0] r_addr;
        logic [31:0] r_be;
        logic [31:0] r_wd;
        logic [31:0] r_ia;
        lfsr         = 32'h6287;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_req_s_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // known contents in the low 1 KiB
        for (int i = 0; i < NUM_FILL; i++) begin
            write_word(32'(4 * i), fill_word(32'(4 * i)));
        end

        // back-to-back random reads and writes
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r_we   = rand_bits(1);
            r_addr = rand_bits(10);
            r_be   = rand_bits(4);
            r_wd   = rand_bits(32);
            drive_cycle(1'b0, '0, 1'b1, r_we[0], r_addr, r_be[3:0], r_wd);
        end

        // fetches mixed with data writes
        for (int i = 0; i < NUM_FETCH; i++) begin
            r_ia   = rand_bits(10) % 32'd1008;
            r_we   = rand_bits(1);
            r_addr = rand_bits(10);
            r_be   = rand_bits(4);
            r_wd   = rand_bits(32);
            drive_cycle(1'b1, AW'(r_ia), r_we[0], 1'b1, r_addr, r_be[3:0], r_wd);
        end
        idle(2);

        // unmapped accesses
        write_word(32'h0001_0010, 32'hDEAD_BEEF);
        write_word(32'h1500_0008, 32'hFFFF_FFFF);
        for (int i = 0; i < 6; i++) begin
            r_addr     = rand_bits(31);
            r_addr[31] = 1'b1;
            write_word(r_addr, rand_bits(32));
            read_word(r_addr);
        end
        read_word(32'h0000_0010);
        read_word(32'h0001_0010);
        read_word(32'h1500_0008);
        read_word(`MM_TIMER_MASK_ADDR);
        read_word(`MM_TIMER_CNT_ADDR);
        read_word(`MM_TEST_STATUS_ADDR);
        read_word(`MM_EXIT_ADDR);
        idle(2);

        // timer with its interrupt line unmasked
        write_word(`MM_TIMER_MASK_ADDR, 32'h1 << `MM_TIMER_IRQ_ID);
        write_word(`MM_TIMER_CNT_ADDR, 32'(TIMER_N));
        read_word(`MM_TIMER_CNT_ADDR);
        read_word(`MM_TIMER_MASK_ADDR);
        read_word(`MM_TIMER_CNT_ADDR);
        wait_irq(TIMER_N + 5);
        irq_ack_i = 1'b1;
        irq_id_i  = 5'd2;
        idle(3);
        irq_id_i = `MM_TIMER_IRQ_ID;
        idle(1);
        irq_ack_i = 1'b0;
        idle(1);
        check_value("irq_o", 128'(irq_o), 128'(1'b0));

        // masked timer stays quiet
        write_word(`MM_TIMER_MASK_ADDR, 32'h0);
        write_word(`MM_TIMER_CNT_ADDR, 32'd8);
        idle(12);
        check_value("irq_o", 128'(irq_o), 128'(1'b0));

        // status pulses and exit value
        write_word(`MM_TEST_STATUS_ADDR, `MM_TEST_PASS_CODE);
        idle(2);
        write_word(`MM_TEST_STATUS_ADDR, `MM_TEST_FAIL_CODE);
        idle(2);
        write_word(`MM_TEST_STATUS_ADDR, 32'h0000_0042);
        idle(2);
        write_word(`MM_EXIT_ADDR, 32'hC0DE_0017);
        read_word(`MM_TEST_STATUS_ADDR);
        read_word(`MM_EXIT_ADDR);
        idle(3);
        wait_responses(10);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mm_ram_props.sv
/*
 * bound checks of the RAM wrapper
 * grants, response timing, status exclusivity and timer interrupt masking
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module mm_ram_props (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      instr_req_i,
    input logic                      instr_gnt_i,
    input logic                      instr_rvalid_i,
    input logic                      data_req_i,
    input logic                      data_gnt_i,
    input logic                      data_rvalid_i,
    input logic                      irq_i,
    input logic                      tests_passed_i,
    input logic                      tests_failed_i,
    input logic [`MM_DATA_WIDTH-1:0] timer_mask_i
);

    a_instr_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_gnt_i == instr_req_i)
        else $error("instruction grant differs from request");

    a_data_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_i == data_req_i)
        else $error("data grant differs from request");

    // exactly one response per granted request, one cycle later
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_i == $past(instr_req_i && instr_gnt_i))
        else $error("instruction rvalid does not follow the grant");

    a_data_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_i == $past(data_req_i && data_gnt_i))
        else $error("data rvalid does not follow the grant");

    a_status_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(tests_passed_i && tests_failed_i))
        else $error("pass and fail status high together");

    a_irq_masked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(irq_i) |-> $past(timer_mask_i[`MM_TIMER_IRQ_ID]))
        else $error("timer interrupt rose while masked");

endmodule

`default_nettype wire

//--- mm_ram_top.sv
/*
 * memory-mapped RAM wrapper for a simulated RISC-V core
 * instruction and data ports over a shared RAM plus pseudo peripherals
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module mm_ram_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          instr_req_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr_i,
    output logic                          instr_gnt_o,
    output logic                          instr_rvalid_o,
    output logic [`MM_INSTR_WIDTH-1:0]    instr_rdata_o,
    input  logic                          data_req_i,
    input  mm_pkg::mm_data_req_t          data_req_s_i,
    output logic                          data_gnt_o,
    output logic                          data_rvalid_o,
    output logic [`MM_DATA_WIDTH-1:0]     data_rdata_o,
    input  logic                          irq_ack_i,
    input  logic [4:0]                    irq_id_i,
    output logic                          irq_o,
    output logic                          tests_passed_o,
    output logic                          tests_failed_o,
    output logic                          exit_valid_o,
    output logic [`MM_DATA_WIDTH-1:0]     exit_value_o
);
    import mm_pkg::*;

    mm_ram_req_t               ram_req;
    mm_periph_req_t            periph_req;
    mm_target_e                target;
    logic [`MM_DATA_WIDTH-1:0] ram_rdata;
    logic [`MM_DATA_WIDTH-1:0] periph_rdata;

    // RAM never stalls, so every request is granted at once
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    mm_addr_decode u_decode (
        .data_req_i   (data_req_i),
        .data_req_s_i (data_req_s_i),
        .ram_req_o    (ram_req),
        .periph_req_o (periph_req),
        .target_o     (target)
    );

    mm_dp_ram u_ram (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .ram_req_i      (ram_req),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_rdata_o   (ram_rdata)
    );

    mm_periph u_periph (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .periph_req_i   (periph_req),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .rdata_o        (periph_rdata),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    mm_rsp_mux u_rsp (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .target_i       (target),
        .ram_rdata_i    (ram_rdata),
        .periph_rdata_i (periph_rdata),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o)
    );

endmodule

`default_nettype wire

//--- mm_rsp_mux.sv
/*
 * data response unit
 * one-cycle rvalid and read data select between RAM and peripherals
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module mm_rsp_mux (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      data_req_i,
    input  mm_pkg::mm_target_e        target_i,
    input  logic [`MM_DATA_WIDTH-1:0] ram_rdata_i,
    input  logic [`MM_DATA_WIDTH-1:0] periph_rdata_i,
    output logic                      data_rvalid_o,
    output logic [`MM_DATA_WIDTH-1:0] data_rdata_o
);
    import mm_pkg::*;

    mm_target_e target_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            target_q      <= TGT_ERR;
            data_rvalid_o <= 1'b0;
        end else begin
            target_q      <= target_i;
            data_rvalid_o <= data_req_i;
        end
    end

    // error accesses read as zero
    always_comb begin
        case (target_q)
            TGT_RAM:    data_rdata_o = ram_rdata_i;
            TGT_PERIPH: data_rdata_o = periph_rdata_i;
            default:    data_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- mm_periph.sv
/*
 * pseudo peripherals of the RAM wrapper
 * countdown timer with interrupt, test-status and exit registers
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module mm_periph (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  mm_pkg::mm_periph_req_t    periph_req_i,
    input  logic                      irq_ack_i,
    input  logic [4:0]                irq_id_i,
    output logic [`MM_DATA_WIDTH-1:0] rdata_o,
    output logic                      irq_o,
    output logic                      tests_passed_o,
    output logic                      tests_failed_o,
    output logic                      exit_valid_o,
    output logic [`MM_DATA_WIDTH-1:0] exit_value_o
);
    import mm_pkg::*;

    logic [`MM_DATA_WIDTH-1:0] timer_mask_q;
    logic [`MM_DATA_WIDTH-1:0] timer_cnt_q;
    logic                      wr;
    logic                      mask_wr;
    logic                      cnt_wr;
    logic                      status_wr;
    logic                      exit_wr;
    logic                      timer_fire;
    logic                      irq_clr;

    assign wr        = periph_req_i.en & periph_req_i.we;
    assign mask_wr   = wr && (periph_req_i.reg_sel == REG_TIMER_MASK);
    assign cnt_wr    = wr && (periph_req_i.reg_sel == REG_TIMER_CNT);
    assign status_wr = wr && (periph_req_i.reg_sel == REG_TEST_STATUS);
    assign exit_wr   = wr && (periph_req_i.reg_sel == REG_EXIT);

    // count reaches zero on this edge and the timer line is unmasked
    assign timer_fire = !mask_wr && !cnt_wr && (timer_cnt_q == 1)
                        && timer_mask_q[`MM_TIMER_IRQ_ID];
    assign irq_clr    = irq_ack_i && (irq_id_i == `MM_TIMER_IRQ_ID);

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
            irq_o        <= 1'b0;
        end else begin
            if (mask_wr) begin
                timer_mask_q <= periph_req_i.wdata;
            end

            // any timer write holds off the decrement for that cycle
            if (cnt_wr) begin
                timer_cnt_q <= periph_req_i.wdata;
            end else if (!mask_wr && timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
            end

            // acknowledge wins over a new event in the same cycle
            if (irq_clr) begin
                irq_o <= 1'b0;
            end else if (timer_fire) begin
                irq_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            tests_passed_o <= status_wr && (periph_req_i.wdata == `MM_TEST_PASS_CODE);
            tests_failed_o <= status_wr && (periph_req_i.wdata == `MM_TEST_FAIL_CODE);
            exit_valid_o   <= exit_wr;
            if (exit_wr) begin
                exit_value_o <= periph_req_i.wdata;
            end
        end
    end

    // read-back sees the register before a write in the same cycle
    always_ff @(posedge clk_i) begin
        if (periph_req_i.en) begin
            if (periph_req_i.we) begin
                rdata_o <= '0;
            end else if (periph_req_i.reg_sel == REG_TIMER_MASK) begin
                rdata_o <= timer_mask_q;
            end else if (periph_req_i.reg_sel == REG_TIMER_CNT) begin
                rdata_o <= timer_cnt_q;
            end else begin
                rdata_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- mm_dp_ram.sv
/*
 * byte-addressed dual-port RAM
 * wide instruction fetch port and a byte-enabled 32-bit data port
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module mm_dp_ram (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          instr_req_i,
    input  logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr_i,
    input  mm_pkg::mm_ram_req_t           ram_req_i,
    output logic [`MM_INSTR_WIDTH-1:0]    instr_rdata_o,
    output logic                          instr_rvalid_o,
    output logic [`MM_DATA_WIDTH-1:0]     data_rdata_o
);
    localparam int AW          = `MM_RAM_ADDR_WIDTH;
    localparam int MEM_BYTES   = 2 ** AW;
    localparam int INSTR_BYTES = `MM_INSTR_WIDTH / 8;
    localparam int DATA_BYTES  = `MM_DATA_WIDTH / 8;

    logic [7:0]    mem [0:MEM_BYTES-1];
    logic [AW-1:0] word_addr;

    assign word_addr = {ram_req_i.addr[AW-1:2], 2'b00};

    // fetch wraps around the top of the address space
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_addr_i + AW'(i)];
            end
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    // data port writes take only the enabled bytes
    always_ff @(posedge clk_i) begin
        if (ram_req_i.en) begin
            if (ram_req_i.we) begin
                for (int k = 0; k < DATA_BYTES; k++) begin
                    if (ram_req_i.be[k]) begin
                        mem[word_addr + AW'(k)] <= ram_req_i.wdata[8*k +: 8];
                    end
                end
            end else begin
                for (int k = 0; k < DATA_BYTES; k++) begin
                    data_rdata_o[8*k +: 8] <= mem[word_addr + AW'(k)];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mm_addr_decode.sv
/*
 * data port address decoder
 * routes each request to the RAM, the peripheral registers or the error path
 */
`timescale 1ns/1ns
`default_nettype none

`include "mm_settings.svh"

module mm_addr_decode (
    input  logic                   data_req_i,
    input  mm_pkg::mm_data_req_t   data_req_s_i,
    output mm_pkg::mm_ram_req_t    ram_req_o,
    output mm_pkg::mm_periph_req_t periph_req_o,
    output mm_pkg::mm_target_e     target_o
);
    import mm_pkg::*;

    logic in_ram;
    logic reg_hit;

    // everything above the RAM window must be zero
    assign in_ram = (data_req_s_i.addr[31:`MM_RAM_ADDR_WIDTH] == '0);

    always_comb begin
        ram_req_o    = '0;
        periph_req_o = '0;
        target_o     = TGT_ERR;
        reg_hit      = 1'b1;

        case (data_req_s_i.addr)
            `MM_TIMER_MASK_ADDR:  periph_req_o.reg_sel = REG_TIMER_MASK;
            `MM_TIMER_CNT_ADDR:   periph_req_o.reg_sel = REG_TIMER_CNT;
            `MM_TEST_STATUS_ADDR: periph_req_o.reg_sel = REG_TEST_STATUS;
            `MM_EXIT_ADDR:        periph_req_o.reg_sel = REG_EXIT;
            default:              reg_hit = 1'b0;
        endcase

        if (in_ram) begin
            target_o        = TGT_RAM;
            ram_req_o.en    = data_req_i;
            ram_req_o.addr  = data_req_s_i.addr[`MM_RAM_ADDR_WIDTH-1:0];
            ram_req_o.we    = data_req_s_i.we;
            ram_req_o.be    = data_req_s_i.be;
            ram_req_o.wdata = data_req_s_i.wdata;
        end else if (reg_hit) begin
            target_o           = TGT_PERIPH;
            periph_req_o.en    = data_req_i;
            periph_req_o.we    = data_req_s_i.we;
            periph_req_o.wdata = data_req_s_i.wdata;
        end
        // unmapped accesses leave both requests idle
    end

endmodule

`default_nettype wire

//--- mm_pkg.sv
/*
 * shared types of the memory-mapped RAM wrapper
 * access targets, peripheral register select and request structs
 */
`default_nettype none

`include "mm_settings.svh"

package mm_pkg;

    // where a data access ends up
    typedef enum logic [1:0] {
        TGT_RAM    = 2'd0,
        TGT_PERIPH = 2'd1,
        TGT_ERR    = 2'd2
    } mm_target_e;

    typedef enum logic [1:0] {
        REG_TIMER_MASK  = 2'd0,
        REG_TIMER_CNT   = 2'd1,
        REG_TEST_STATUS = 2'd2,
        REG_EXIT        = 2'd3
    } mm_periph_reg_e;

    // data port request as seen from the core
    typedef struct packed {
        logic [31:0]                 addr;
        logic                        we;
        logic [3:0]                  be;
        logic [`MM_DATA_WIDTH-1:0]   wdata;
    } mm_data_req_t;

    typedef struct packed {
        logic                          en;
        logic [`MM_RAM_ADDR_WIDTH-1:0] addr;
        logic                          we;
        logic [3:0]                    be;
        logic [`MM_DATA_WIDTH-1:0]     wdata;
    } mm_ram_req_t;

    typedef struct packed {
        logic                      en;
        mm_periph_reg_e            reg_sel;
        logic                      we;
        logic [`MM_DATA_WIDTH-1:0] wdata;
    } mm_periph_req_t;

endpackage

`default_nettype wire

//--- mm_settings.svh
/*
 * memory-mapped RAM wrapper settings
 * widths, peripheral register map, timer interrupt ID and test codes
 */
`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// RAM size is 2**MM_RAM_ADDR_WIDTH bytes
`define MM_RAM_ADDR_WIDTH   16
`define MM_INSTR_WIDTH      128
`define MM_DATA_WIDTH       32

// peripheral register map
`define MM_TIMER_MASK_ADDR  32'h1500_0000
`define MM_TIMER_CNT_ADDR   32'h1500_0004
`define MM_TEST_STATUS_ADDR 32'h2000_0000
`define MM_EXIT_ADDR        32'h2000_0004

// interrupt line used by the countdown timer
`define MM_TIMER_IRQ_ID     5'd3

// values written by the test program to the status register
`define MM_TEST_PASS_CODE   32'd123456789
`define MM_TEST_FAIL_CODE   32'd1

`endif
